// File: Bender.yml
package:
  name: matrix_multiplier

sources:
  - files:
      - rtl/matmul_pkg.sv
      - rtl/matrix_if.sv
      - rtl/matrix_order.sv
      - rtl/dot_product_engine.sv
      - rtl/matrix_restore.sv
      - rtl/matrix_multiplier.sv
  - target: test
    files:
      - testbench/matrix_multiplier_checker.sv
      - testbench/matrix_multiplier_tb.sv

// File: rtl/dot_product_engine.sv
`timescale 1ns/1ps

module dot_product_engine import matmul_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       en,
    matrix_if.consumer op_a,
    matrix_if.consumer op_b,
    matrix_if.producer result,
    output logic       restore_start,
    input  logic       restore_done,
    output dim_t       r_out,
    output dim_t       c_out,
    output logic       valid,
    output logic       busy
);

    typedef enum logic [2:0] {
        st_idle,
        st_calc,
        st_start,
        st_wait,
        st_done,
        st_error
    } state_t;

    state_t                 state;
    logic [index_width-1:0] counter;
    dim_t                   row;
    dim_t                   col;
    elem_t                  prod [dim_max];
    elem_t                  sum;

    assign row = dim_t'(counter / dim_max);
    assign col = dim_t'(counter % dim_max);

    assign result.rows = r_out;
    assign result.cols = c_out;

    // row of A times column of B, everything wraps at 9 bits
    always_comb begin
        sum = '0;
        for (int i = 0; i < dim_max; i++) begin
            prod[i] = op_a.grid[row * dim_max + i] * op_b.grid[i * dim_max + col];
            sum     = sum + prod[i];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= st_idle;
            counter        <= '0;
            busy           <= 1'b0;
            valid          <= 1'b1;
            r_out          <= '0;
            c_out          <= '0;
            restore_start  <= 1'b0;
            result.loaded  <= 1'b0;
        end else if (!en) begin
            state          <= st_idle;
            counter        <= '0;
            busy           <= 1'b0;
            valid          <= 1'b1;
            r_out          <= '0;
            c_out          <= '0;
            restore_start  <= 1'b0;
            result.loaded  <= 1'b0;
        end else begin
            restore_start <= 1'b0;
            case (state)
                st_idle: begin
                    busy <= 1'b1;
                    // both operands registered, check the inner dimension
                    if (op_a.loaded && op_b.loaded) begin
                        if (op_a.cols == op_b.rows) begin
                            r_out   <= op_a.rows;
                            c_out   <= op_b.cols;
                            counter <= '0;
                            state   <= st_calc;
                        end else begin
                            valid <= 1'b0;
                            state <= st_error;
                        end
                    end
                end
                st_calc: begin
                    if (counter == index_width'(elem_count - 1)) begin
                        result.loaded <= 1'b1;
                        state         <= st_start;
                    end else begin
                        counter <= counter + 1'b1;
                    end
                end
                st_start: begin
                    restore_start <= 1'b1;
                    state         <= st_wait;
                end
                st_wait: begin
                    if (restore_done) begin
                        busy  <= 1'b0;
                        state <= st_done;
                    end
                end
                // done and error both hold until en drops
                default: begin
                end
            endcase
        end
    end

    // one result slot per cycle
    always_ff @(posedge clk) begin
        if (state == st_calc) begin
            result.grid[counter] <= sum;
        end
    end

endmodule

// File: rtl/matmul_pkg.sv
package matmul_pkg;

    // element and grid geometry
    localparam int data_width  = 9;
    localparam int dim_max     = 5;
    localparam int elem_count  = dim_max * dim_max;

    // 3 bits hold a count of 1..5
    localparam int dim_width   = 3;

    // counts 0..24 across the grid
    localparam int index_width = 5;

    // one matrix element, products and sums wrap at this width
    typedef logic [data_width-1:0] elem_t;

    // row or column count
    typedef logic [dim_width-1:0] dim_t;

    // 25 slots, slot k is row k/5 and column k mod 5 when used as a grid.
    // the same type carries the compact row-major lists at the top level
    typedef elem_t [elem_count-1:0] grid_t;

endpackage

// File: rtl/matrix_if.sv
`timescale 1ns/1ps

interface matrix_if import matmul_pkg::*; ();

    dim_t  rows;
    dim_t  cols;
    grid_t grid;

    // grid content is complete
    logic  loaded;

    modport producer (
        output rows,
        output cols,
        output grid,
        output loaded
    );

    modport consumer (
        input  rows,
        input  cols,
        input  grid,
        input  loaded
    );

endinterface

// File: rtl/matrix_multiplier.sv
`timescale 1ns/1ps

module matrix_multiplier import matmul_pkg::*; (
    input  logic  clk,
    input  logic  reset_n,
    input  logic  en,
    input  dim_t  r1,
    input  dim_t  c1,
    input  dim_t  r2,
    input  dim_t  c2,
    input  grid_t data1_in,
    input  grid_t data2_in,
    output dim_t  r_out,
    output dim_t  c_out,
    output grid_t data_out,
    output logic  valid,
    output logic  busy
);

    logic restore_start;
    logic restore_done;

    matrix_if op_a ();
    matrix_if op_b ();
    matrix_if result ();

    // operand A
    matrix_order order_a (
        .clk      (clk),
        .reset_n  (reset_n),
        .rows     (r1),
        .cols     (c1),
        .data_in  (data1_in),
        .en       (en),
        .grid_out (op_a)
    );

    // operand B
    matrix_order order_b (
        .clk      (clk),
        .reset_n  (reset_n),
        .rows     (r2),
        .cols     (c2),
        .data_in  (data2_in),
        .en       (en),
        .grid_out (op_b)
    );

    dot_product_engine engine (
        .clk           (clk),
        .reset_n       (reset_n),
        .en            (en),
        .op_a          (op_a),
        .op_b          (op_b),
        .result        (result),
        .restore_start (restore_start),
        .restore_done  (restore_done),
        .r_out         (r_out),
        .c_out         (c_out),
        .valid         (valid),
        .busy          (busy)
    );

    matrix_restore restore (
        .clk           (clk),
        .reset_n       (reset_n),
        .result        (result),
        .restore_start (restore_start),
        .en            (en),
        .data_out      (data_out),
        .restore_done  (restore_done)
    );

endmodule

// File: rtl/matrix_order.sv
`timescale 1ns/1ps

module matrix_order import matmul_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  dim_t       rows,
    input  dim_t       cols,
    input  grid_t      data_in,
    input  logic       en,
    matrix_if.producer grid_out
);

    grid_t padded;

    // compact row-major list into the fixed 5x5 layout
    always_comb begin
        padded = '0;
        for (int r = 0; r < dim_max; r++) begin
            for (int c = 0; c < dim_max; c++) begin
                if (r < rows && c < cols) begin
                    padded[r * dim_max + c] = data_in[r * cols + c];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grid_out.loaded <= 1'b0;
        end else if (!en) begin
            grid_out.loaded <= 1'b0;
        end else begin
            grid_out.loaded <= 1'b1;
        end
    end

    // capture once per enable, then hold
    always_ff @(posedge clk) begin
        if (!en) begin
            grid_out.grid <= '0;
        end else if (!grid_out.loaded) begin
            grid_out.grid <= padded;
            grid_out.rows <= rows;
            grid_out.cols <= cols;
        end
    end

endmodule

// File: rtl/matrix_restore.sv
`timescale 1ns/1ps

module matrix_restore import matmul_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    matrix_if.consumer result,
    input  logic       restore_start,
    input  logic       en,
    output grid_t      data_out,
    output logic       restore_done
);

    grid_t compact;

    // 5x5 grid back to an r1 x c2 row-major list
    always_comb begin
        compact = '0;
        for (int r = 0; r < dim_max; r++) begin
            for (int c = 0; c < dim_max; c++) begin
                if (r < result.rows && c < result.cols) begin
                    compact[r * result.cols + c] = result.grid[r * dim_max + c];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_out     <= '0;
            restore_done <= 1'b0;
        end else if (!en) begin
            data_out     <= '0;
            restore_done <= 1'b0;
        end else if (restore_start && result.loaded) begin
            data_out     <= compact;
            restore_done <= 1'b1;
        end else begin
            // data_out holds until en falls
            restore_done <= 1'b0;
        end
    end

endmodule

// File: sources.f
rtl/matmul_pkg.sv
rtl/matrix_if.sv
rtl/matrix_order.sv
rtl/dot_product_engine.sv
rtl/matrix_restore.sv
rtl/matrix_multiplier.sv
testbench/matrix_multiplier_checker.sv
testbench/matrix_multiplier_tb.sv

// File: testbench/matrix_multiplier_checker.sv
`timescale 1ns/1ps

module matrix_multiplier_checker import matmul_pkg::*; (
    input logic clk,
    input logic reset_n,
    input logic en,
    input logic busy,
    input logic valid,
    input logic restore_start,
    input logic restore_done
);

    // busy drops on a delivered result or on a cancelled enable
    busy_release: assert property (
        @(posedge clk) disable iff (!reset_n)
        $fell(busy) |-> $past(restore_done) || !$past(en)
    ) else $error("busy fell without restore_done while en was high");

    start_single_cycle: assert property (
        @(posedge clk) disable iff (!reset_n)
        restore_start |=> !restore_start
    ) else $error("restore_start lasted longer than one cycle");

    // a rejected pair never reaches the packer
    no_start_on_mismatch: assert property (
        @(posedge clk) disable iff (!reset_n)
        (!valid && en) |=> !restore_start
    ) else $error("restore_start followed a dimension mismatch");

    done_follows_start: assert property (
        @(posedge clk) disable iff (!reset_n)
        restore_done |-> $past(restore_start)
    ) else $error("restore_done without a preceding restore_start");

endmodule

bind dot_product_engine matrix_multiplier_checker protocol_checker (
    .clk           (clk),
    .reset_n       (reset_n),
    .en            (en),
    .busy          (busy),
    .valid         (valid),
    .restore_start (restore_start),
    .restore_done  (restore_done)
);

// File: testbench/matrix_multiplier_tb.sv
`timescale 1ns/1ps

module matrix_multiplier_tb import matmul_pkg::*; ();

    typedef enum logic [2:0] {
        fill_ones,
        fill_ramp,
        fill_random,
        fill_max,
        fill_rand_dims
    } fill_t;

    typedef struct packed {
        dim_t  r1;
        dim_t  c1;
        dim_t  r2;
        dim_t  c2;
        fill_t fill;
    } case_t;

    logic  clk;
    logic  reset_n;
    logic  en;
    dim_t  r1;
    dim_t  c1;
    dim_t  r2;
    dim_t  c2;
    grid_t data1_in;
    grid_t data2_in;
    dim_t  r_out;
    dim_t  c_out;
    grid_t data_out;
    logic  valid;
    logic  busy;

    integer seed = 32'he6a9;
    int     wait_limit = 100;
    int     error_count = 0;
    int     check_count = 0;
    bit     aborted = 1'b0;

    // dims of rand_dims entries are drawn at run time
    case_t case_table [11] = '{
        '{3'd5, 3'd5, 3'd5, 3'd5, fill_ones},
        '{3'd2, 3'd3, 3'd3, 3'd4, fill_ramp},
        '{3'd1, 3'd5, 3'd5, 3'd1, fill_ramp},
        '{3'd4, 3'd1, 3'd1, 3'd3, fill_ramp},
        '{3'd5, 3'd5, 3'd5, 3'd5, fill_max},
        '{3'd2, 3'd3, 3'd2, 3'd3, fill_ramp},
        '{3'd3, 3'd3, 3'd3, 3'd3, fill_random},
        '{3'd5, 3'd5, 3'd5, 3'd5, fill_random},
        '{3'd0, 3'd0, 3'd0, 3'd0, fill_rand_dims},
        '{3'd0, 3'd0, 3'd0, 3'd0, fill_rand_dims},
        '{3'd0, 3'd0, 3'd0, 3'd0, fill_rand_dims}
    };

    matrix_multiplier UUT (
        .clk      (clk),
        .reset_n  (reset_n),
        .en       (en),
        .r1       (r1),
        .c1       (c1),
        .r2       (r2),
        .c2       (c2),
        .data1_in (data1_in),
        .data2_in (data2_in),
        .r_out    (r_out),
        .c_out    (c_out),
        .data_out (data_out),
        .valid    (valid),
        .busy     (busy)
    );

    always #10 clk = ~clk;

    function automatic elem_t operand_value(fill_t fill, int k, int which);
        case (fill)
            fill_ones: return elem_t'(1);
            fill_ramp: return (which == 0) ? elem_t'(k + 1) : elem_t'(k * 3 + 2);
            fill_max:  return elem_t'(9'h1ff);
            default:   return elem_t'($random(seed));
        endcase
    endfunction

    // compact row-major product, everything modulo 512
    function automatic grid_t model_product(grid_t a, grid_t b, int n_r1, int n_c1, int n_c2);
        grid_t prod;
        int    acc;
        prod = '0;
        for (int i = 0; i < n_r1; i++) begin
            for (int j = 0; j < n_c2; j++) begin
                acc = 0;
                for (int k = 0; k < n_c1; k++) begin
                    acc += int'(a[i * n_c1 + k]) * int'(b[k * n_c2 + j]);
                end
                prod[i * n_c2 + j] = elem_t'(acc % 512);
            end
        end
        return prod;
    endfunction

    task automatic load_operands(input case_t tc);
        dim_t n_r1;
        dim_t n_c1;
        dim_t n_r2;
        dim_t n_c2;
        if (tc.fill == fill_rand_dims) begin
            n_r1 = dim_t'($unsigned($random(seed)) % dim_max + 1);
            n_c1 = dim_t'($unsigned($random(seed)) % dim_max + 1);
            n_r2 = n_c1;
            n_c2 = dim_t'($unsigned($random(seed)) % dim_max + 1);
        end else begin
            n_r1 = tc.r1;
            n_c1 = tc.c1;
            n_r2 = tc.r2;
            n_c2 = tc.c2;
        end
        r1 = n_r1;
        c1 = n_c1;
        r2 = n_r2;
        c2 = n_c2;
        // unused slots carry junk that the loaders must ignore
        for (int k = 0; k < elem_count; k++) begin
            if (k < n_r1 * n_c1) begin
                data1_in[k] = operand_value(tc.fill, k, 0);
            end else begin
                data1_in[k] = elem_t'(k * 37 + 11);
            end
            if (k < n_r2 * n_c2) begin
                data2_in[k] = operand_value(tc.fill, k, 1);
            end else begin
                data2_in[k] = elem_t'(k * 37 + 112);
            end
        end
    endtask

    task automatic check_value(input string name, input logic [data_width-1:0] got,
                               input logic [data_width-1:0] expected);
        check_count++;
        assert (got === expected) else begin
            $display("Mismatch %s: got %h expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_outputs(input grid_t exp_data, input dim_t exp_r, input dim_t exp_c,
                                 input logic exp_valid, input logic exp_busy);
        check_value("valid", data_width'(valid), data_width'(exp_valid));
        check_value("busy", data_width'(busy), data_width'(exp_busy));
        check_value("r_out", data_width'(r_out), data_width'(exp_r));
        check_value("c_out", data_width'(c_out), data_width'(exp_c));
        for (int k = 0; k < elem_count; k++) begin
            check_value($sformatf("data_out[%0d]", k), data_out[k], exp_data[k]);
        end
    endtask

    // result ready, or rejected pair
    task automatic wait_for_result(output bit timed_out);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (busy && valid && cycles < wait_limit);
        timed_out = busy && valid;
    endtask

    task automatic wait_for_idle(output bit timed_out);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (busy && cycles < wait_limit);
        timed_out = busy;
    endtask

    task automatic run_case(input int index, input case_t tc);
        grid_t expected;
        bit    mismatch;
        bit    timed_out;
        load_operands(tc);
        mismatch = (c1 != r2);
        expected = model_product(data1_in, data2_in, r1, c1, c2);
        en = 1'b1;
        wait_for_result(timed_out);
        if (timed_out) begin
            $display("case %0d: the design never finished or rejected the operands", index);
            error_count++;
            aborted = 1'b1;
        end else begin
            if (mismatch) begin
                check_outputs('0, '0, '0, 1'b0, 1'b1);
            end else begin
                check_outputs(expected, r1, c2, 1'b1, 1'b0);
            end
            en = 1'b0;
            wait_for_idle(timed_out);
            if (timed_out) begin
                $display("case %0d: busy stayed high after en was dropped", index);
                error_count++;
                aborted = 1'b1;
            end else begin
                // back to idle, nothing left from this case
                check_outputs('0, '0, '0, 1'b1, 1'b0);
            end
        end
    endtask

    initial begin
        clk      = 1'b0;
        reset_n  = 1'b0;
        en       = 1'b0;
        r1       = '0;
        c1       = '0;
        r2       = '0;
        c2       = '0;
        data1_in = '0;
        data2_in = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        check_outputs('0, '0, '0, 1'b1, 1'b0);
        for (int i = 0; i < $size(case_table) && !aborted; i++) begin
            run_case(i, case_table[i]);
        end
        $display("checks: %0d errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
